//--- source/cmdPkg.sv
package cmdPkg;

  localparam int cmdWidth = 32;
  localparam int regNumWidth = 4;
  localparam int dataWidth = 32;
  localparam int flagsWidth = 2;

  // register number of the instruction pointer
  localparam logic [regNumWidth-1:0] regIp = 4'd15;

  // register number fields
  localparam int regS1Lsb = 0;
  localparam int regS0Lsb = 4;
  localparam int regDLsb = 8;
  localparam int regCndLsb = 12;

  // pointer bits, s1 s0 d cnd from ptrLsb upward
  localparam int ptrLsb = 16;
  localparam int ptrS1Bit = ptrLsb;
  localparam int ptrS0Bit = ptrLsb + 1;
  localparam int ptrDBit = ptrLsb + 2;
  localparam int ptrCndBit = ptrLsb + 3;

  // operand flag fields, same order as the pointer bits
  localparam int flagsLsb = 20;
  localparam int flagsS1Lsb = flagsLsb;
  localparam int flagsS0Lsb = flagsLsb + flagsWidth;
  localparam int flagsDLsb = flagsLsb + 2 * flagsWidth;
  localparam int flagsCndLsb = flagsLsb + 3 * flagsWidth;

  // one set bit means read and written back
  localparam logic [flagsWidth-1:0] flagUnused = 2'b11;
  localparam logic [flagsWidth-1:0] flagReadOnly = 2'b00;

  function automatic logic isUsed(input logic [flagsWidth-1:0] flags);
    return flags != flagUnused;
  endfunction

  function automatic logic isWrittenBack(input logic [flagsWidth-1:0] flags);
    return (flags != flagUnused) && (flags != flagReadOnly);
  endfunction

endpackage

//--- source/seqPkg.sv
package seqPkg;

  localparam int stateWidth = 5;

  // start-up chain
  localparam logic [stateWidth-1:0] stWaitForStart = 5'd0;
  localparam logic [stateWidth-1:0] stStartBegin = 5'd1;
  localparam logic [stateWidth-1:0] stReadMemSize = 5'd2;
  localparam logic [stateWidth-1:0] stAfterMemSize = 5'd3;
  localparam logic [stateWidth-1:0] stReadCmd = 5'd4;
  localparam logic [stateWidth-1:0] stReadCmdP = 5'd5;
  localparam logic [stateWidth-1:0] stPreexecute = 5'd6;

  localparam logic [stateWidth-1:0] stWriteRegIp = 5'd7;

  // operand fetch
  localparam logic [stateWidth-1:0] stReadCond = 5'd8;
  localparam logic [stateWidth-1:0] stFillCond = 5'd9;
  localparam logic [stateWidth-1:0] stReadCondP = 5'd10;
  localparam logic [stateWidth-1:0] stReadSrc1 = 5'd11;
  localparam logic [stateWidth-1:0] stFillSrc1 = 5'd12;
  localparam logic [stateWidth-1:0] stReadSrc1P = 5'd13;
  localparam logic [stateWidth-1:0] stReadSrc0 = 5'd14;
  localparam logic [stateWidth-1:0] stFillSrc0 = 5'd15;
  localparam logic [stateWidth-1:0] stReadSrc0P = 5'd16;
  localparam logic [stateWidth-1:0] stReadDst = 5'd17;
  localparam logic [stateWidth-1:0] stFillDstP = 5'd18;

  localparam logic [stateWidth-1:0] stAluBegin = 5'd19;
  localparam logic [stateWidth-1:0] stAluResults = 5'd20;

  // writeback
  localparam logic [stateWidth-1:0] stWritePrep = 5'd21;
  localparam logic [stateWidth-1:0] stWriteDst = 5'd22;
  localparam logic [stateWidth-1:0] stWriteDstP = 5'd23;
  localparam logic [stateWidth-1:0] stWriteCond = 5'd24;
  localparam logic [stateWidth-1:0] stWriteSrc1 = 5'd25;
  localparam logic [stateWidth-1:0] stWriteSrc0 = 5'd26;

  // finish, highest defined code
  localparam logic [stateWidth-1:0] stFinishBegin = 5'd27;
  localparam logic [stateWidth-1:0] stFinishEnd = 5'd28;

endpackage

//--- source/operandFetchPlanner.sv
`timescale 1ns/100ps

module operandFetchPlanner (
  input  logic [cmdPkg::cmdWidth-1:0]   command,
  input  logic                          isCndRead,
  input  logic                          isS1Read,
  input  logic                          isS0Read,
  output logic [seqPkg::stateWidth-1:0] fetchFromCond,
  output logic [seqPkg::stateWidth-1:0] fetchFromSrc1,
  output logic [seqPkg::stateWidth-1:0] fetchFromSrc0,
  output logic [seqPkg::stateWidth-1:0] fetchFromDst
);
  import cmdPkg::*;
  import seqPkg::*;

  logic [regNumWidth-1:0] regNumCnd;
  logic [regNumWidth-1:0] regNumS1;
  logic [regNumWidth-1:0] regNumS0;
  logic [regNumWidth-1:0] regNumD;
  logic cndUsed;
  logic s1Used;
  logic s0Used;
  logic hitCndS1;
  logic hitCndS0;
  logic hitS1S0;
  logic fillCond;
  logic fillS1;
  logic fillS0;
  logic fillDst;

  assign regNumCnd = command[regCndLsb +: regNumWidth];
  assign regNumS1 = command[regS1Lsb +: regNumWidth];
  assign regNumS0 = command[regS0Lsb +: regNumWidth];
  assign regNumD = command[regDLsb +: regNumWidth];

  assign cndUsed = isUsed(command[flagsCndLsb +: flagsWidth]);
  assign s1Used = isUsed(command[flagsS1Lsb +: flagsWidth]);
  assign s0Used = isUsed(command[flagsS0Lsb +: flagsWidth]);

  // earlier operands whose value is already loaded
  assign hitCndS1 = cndUsed && isCndRead && (regNumS1 == regNumCnd);
  assign hitCndS0 = cndUsed && isCndRead && (regNumS0 == regNumCnd);
  assign hitS1S0 = s1Used && isS1Read && (regNumS0 == regNumS1);

  // fill from ip when the register is ip or a copy is already at hand
  assign fillCond = (regNumCnd == regIp);
  assign fillS1 = (regNumS1 == regIp) || hitCndS1;
  assign fillS0 = (regNumS0 == regIp) || hitCndS0 || hitS1S0;
  assign fillDst = (regNumD == regIp)
                || (cndUsed && isCndRead && (regNumD == regNumCnd))
                || (s1Used && isS1Read && (regNumD == regNumS1))
                || (s0Used && isS0Read && (regNumD == regNumS0));

  // each point falls through to the next used operand, ALU last
  assign fetchFromDst = command[ptrDBit]
                      ? (fillDst ? stFillDstP : stReadDst)
                      : stAluBegin;

  assign fetchFromSrc0 = s0Used
                       ? (fillS0 ? stFillSrc0 : stReadSrc0)
                       : fetchFromDst;

  assign fetchFromSrc1 = s1Used
                       ? (fillS1 ? stFillSrc1 : stReadSrc1)
                       : fetchFromSrc0;

  assign fetchFromCond = cndUsed
                       ? (fillCond ? stFillCond : stReadCond)
                       : fetchFromSrc1;

endmodule

//--- source/writebackPermit.sv
`timescale 1ns/100ps

module writebackPermit (
  input  logic [cmdPkg::cmdWidth-1:0]  command,
  input  logic [cmdPkg::dataWidth-1:0] cond,
  output logic                         isIpSaveAllowed,
  output logic                         isDSaveAllowed,
  output logic                         isDSavePtrAllowed,
  output logic                         isCndSaveAllowed,
  output logic                         isS1SaveAllowed,
  output logic                         isS0SaveAllowed
);
  import cmdPkg::*;

  logic [regNumWidth-1:0] regNumCnd;
  logic [regNumWidth-1:0] regNumS1;
  logic [regNumWidth-1:0] regNumS0;
  logic [regNumWidth-1:0] regNumD;
  logic dUsed;
  logic cndWritten;
  logic s1Written;
  logic s0Written;
  logic condTrue;

  assign regNumCnd = command[regCndLsb +: regNumWidth];
  assign regNumS1 = command[regS1Lsb +: regNumWidth];
  assign regNumS0 = command[regS0Lsb +: regNumWidth];
  assign regNumD = command[regDLsb +: regNumWidth];

  assign dUsed = isUsed(command[flagsDLsb +: flagsWidth]);
  assign cndWritten = isWrittenBack(command[flagsCndLsb +: flagsWidth]);
  assign s1Written = isWrittenBack(command[flagsS1Lsb +: flagsWidth]);
  assign s0Written = isWrittenBack(command[flagsS0Lsb +: flagsWidth]);

  // no condition operand counts as true
  assign condTrue = !isUsed(command[flagsCndLsb +: flagsWidth]) || (cond != '0);

  assign isDSaveAllowed = dUsed && condTrue;
  assign isDSavePtrAllowed = !dUsed && command[ptrDBit] && condTrue;

  // d outranks s0, which outranks s1, which outranks cnd
  assign isCndSaveAllowed = cndWritten
                         && (regNumD != regNumCnd || !isDSaveAllowed)
                         && (regNumS1 != regNumCnd || !s1Written)
                         && (regNumS0 != regNumCnd || !s0Written);

  assign isS1SaveAllowed = s1Written
                        && (regNumD != regNumS1 || !isDSaveAllowed)
                        && (regNumS0 != regNumS1 || !s0Written);

  assign isS0SaveAllowed = s0Written
                        && (regNumD != regNumS0 || !isDSaveAllowed);

  // ip increment is skipped when the command itself writes the ip
  assign isIpSaveAllowed = !((isDSaveAllowed && regNumD == regIp)
                          || (cndWritten && regNumCnd == regIp)
                          || (s1Written && regNumS1 == regIp)
                          || (s0Written && regNumS0 == regIp));

endmodule

//--- source/instructionSequencer.sv
`timescale 1ns/100ps

module instructionSequencer (
  input  logic                          next_state,
  input  logic                          rst,
  input  logic [cmdPkg::cmdWidth-1:0]   command,
  input  logic [cmdPkg::dataWidth-1:0]  cond,
  input  logic                          isIpSaveAllowed,
  input  logic                          isDSaveAllowed,
  input  logic                          isDSavePtrAllowed,
  input  logic                          isCndSaveAllowed,
  input  logic                          isS1SaveAllowed,
  input  logic                          isS0SaveAllowed,
  input  logic [seqPkg::stateWidth-1:0] fetchFromCond,
  input  logic [seqPkg::stateWidth-1:0] fetchFromSrc1,
  input  logic [seqPkg::stateWidth-1:0] fetchFromSrc0,
  input  logic [seqPkg::stateWidth-1:0] fetchFromDst,
  output logic [seqPkg::stateWidth-1:0] state,
  output logic                          nextStateDn
);
  import cmdPkg::*;
  import seqPkg::*;

  logic condIsRead;
  logic ipIsWritten;
  logic dWrittenBack;
  logic ipDetour;
  logic [stateWidth-1:0] afterCondFetch;
  logic [stateWidth-1:0] afterDst;
  logic [stateWidth-1:0] afterCond;
  logic [stateWidth-1:0] afterSrc1;

  assign dWrittenBack = isWrittenBack(command[flagsDLsb +: flagsWidth]);

  // false condition jumps to the ip write once per instruction
  assign ipDetour = isIpSaveAllowed && (cond == '0) && !ipIsWritten;
  assign afterCondFetch = ipDetour ? stWriteRegIp : fetchFromSrc1;

  // writeback order d, cnd, s1, s0
  assign afterSrc1 = isS0SaveAllowed ? stWriteSrc0 : stFinishBegin;
  assign afterCond = isS1SaveAllowed ? stWriteSrc1 : afterSrc1;
  assign afterDst = isCndSaveAllowed ? stWriteCond : afterCond;

  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state <= stWaitForStart;
      condIsRead <= 1'b0;
      ipIsWritten <= 1'b0;
      nextStateDn <= 1'b0;
    end else begin
      nextStateDn <= ~nextStateDn;
      case (state)
        stWaitForStart: state <= stStartBegin;
        stStartBegin:   state <= stReadMemSize;
        stReadMemSize:  state <= stAfterMemSize;
        stAfterMemSize: state <= stReadCmd;
        stReadCmd: begin
          // new instruction, forget what the last one fetched
          condIsRead <= 1'b0;
          ipIsWritten <= 1'b0;
          state <= stReadCmdP;
        end
        stReadCmdP:     state <= stPreexecute;
        stPreexecute:   state <= isIpSaveAllowed ? stWriteRegIp : fetchFromCond;
        stWriteRegIp: begin
          ipIsWritten <= 1'b1;
          state <= condIsRead ? fetchFromSrc1 : fetchFromCond;
        end
        stReadCond, stFillCond: begin
          condIsRead <= 1'b1;
          state <= command[ptrCndBit] ? stReadCondP : afterCondFetch;
        end
        stReadCondP:    state <= afterCondFetch;
        stReadSrc1, stFillSrc1: begin
          state <= command[ptrS1Bit] ? stReadSrc1P : fetchFromSrc0;
        end
        stReadSrc1P:    state <= fetchFromSrc0;
        stReadSrc0, stFillSrc0: begin
          state <= command[ptrS0Bit] ? stReadSrc0P : fetchFromDst;
        end
        stReadSrc0P:    state <= fetchFromDst;
        stReadDst, stFillDstP: state <= stAluBegin;
        stAluBegin:     state <= stAluResults;
        stAluResults:   state <= stWritePrep;
        stWritePrep: begin
          if (isDSaveAllowed) begin
            state <= command[ptrDBit] ? stWriteDstP : stWriteDst;
          end else if (isDSavePtrAllowed) begin
            state <= stWriteDstP;
          end else begin
            state <= afterDst;
          end
        end
        // pointer store first, then the register itself if written back
        stWriteDstP:    state <= dWrittenBack ? stWriteDst : afterDst;
        stWriteDst:     state <= afterDst;
        stWriteCond:    state <= afterCond;
        stWriteSrc1:    state <= afterSrc1;
        stWriteSrc0:    state <= stFinishBegin;
        stFinishBegin:  state <= stFinishEnd;
        stFinishEnd:    state <= stReadCmd;
        default:        state <= stWaitForStart;
      endcase
    end
  end

  // only defined codes ever reach the state register
  assert property (@(posedge next_state) disable iff (rst) state <= stFinishEnd)
    else $error("undefined state code %0d", state);

  // done line flips on every strobe once out of reset
  assert property (@(posedge next_state) disable iff (rst)
    !$past(rst) |-> (nextStateDn != $past(nextStateDn)))
    else $error("nextStateDn missed a toggle");

endmodule

//--- source/stateManager.sv
`timescale 1ns/100ps

module stateManager (
  input  logic                          next_state,
  input  logic                          rst,
  input  logic [cmdPkg::cmdWidth-1:0]   command,
  input  logic [cmdPkg::dataWidth-1:0]  cond,
  input  logic                          isCndRead,
  input  logic                          isS1Read,
  input  logic                          isS0Read,
  output logic [seqPkg::stateWidth-1:0] state,
  output logic                          nextStateDn,
  output logic                          isIpSaveAllowed,
  output logic                          isDSaveAllowed,
  output logic                          isDSavePtrAllowed,
  output logic                          isCndSaveAllowed,
  output logic                          isS1SaveAllowed,
  output logic                          isS0SaveAllowed
);
  import seqPkg::*;

  logic [stateWidth-1:0] fetchFromCond;
  logic [stateWidth-1:0] fetchFromSrc1;
  logic [stateWidth-1:0] fetchFromSrc0;
  logic [stateWidth-1:0] fetchFromDst;

  writebackPermit permit (
    .command          (command),
    .cond             (cond),
    .isIpSaveAllowed  (isIpSaveAllowed),
    .isDSaveAllowed   (isDSaveAllowed),
    .isDSavePtrAllowed(isDSavePtrAllowed),
    .isCndSaveAllowed (isCndSaveAllowed),
    .isS1SaveAllowed  (isS1SaveAllowed),
    .isS0SaveAllowed  (isS0SaveAllowed)
  );

  operandFetchPlanner planner (
    .command      (command),
    .isCndRead    (isCndRead),
    .isS1Read     (isS1Read),
    .isS0Read     (isS0Read),
    .fetchFromCond(fetchFromCond),
    .fetchFromSrc1(fetchFromSrc1),
    .fetchFromSrc0(fetchFromSrc0),
    .fetchFromDst (fetchFromDst)
  );

  instructionSequencer sequencer (
    .next_state       (next_state),
    .rst              (rst),
    .command          (command),
    .cond             (cond),
    .isIpSaveAllowed  (isIpSaveAllowed),
    .isDSaveAllowed   (isDSaveAllowed),
    .isDSavePtrAllowed(isDSavePtrAllowed),
    .isCndSaveAllowed (isCndSaveAllowed),
    .isS1SaveAllowed  (isS1SaveAllowed),
    .isS0SaveAllowed  (isS0SaveAllowed),
    .fetchFromCond    (fetchFromCond),
    .fetchFromSrc1    (fetchFromSrc1),
    .fetchFromSrc0    (fetchFromSrc0),
    .fetchFromDst     (fetchFromDst),
    .state            (state),
    .nextStateDn      (nextStateDn)
  );

endmodule

//--- include/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the closing report
int checkCount = 0;
int errorCount = 0;

task automatic checkState(
  input string                          name,
  input logic [seqPkg::stateWidth-1:0] expected,
  input logic [seqPkg::stateWidth-1:0] actual
);
  checkCount++;
  if (actual !== expected) begin
    errorCount++;
    $display("ERROR: time %0t %s expected %0d actual %0d", $time, name, expected, actual);
  end
endtask

task automatic checkFlag(
  input string name,
  input logic  expected,
  input logic  actual
);
  checkCount++;
  if (actual !== expected) begin
    errorCount++;
    $display("ERROR: time %0t %s expected %b actual %b", $time, name, expected, actual);
  end
endtask

// done line must match and must differ from its value before the edge
task automatic checkToggle(
  input string name,
  input logic  previous,
  input logic  expected,
  input logic  actual
);
  checkCount++;
  if (actual !== expected || actual === previous) begin
    errorCount++;
    $display("ERROR: time %0t %s expected %b actual %b (was %b)",
             $time, name, expected, actual, previous);
  end
endtask

`endif

//--- verif/stateManagerTb.sv
`timescale 1ns/100ps

module stateManagerTb;
  import cmdPkg::*;
  import seqPkg::*;

  localparam int resetCycles = 5;
  localparam int clkPeriodNs = 4;
  localparam int maxRows = 64;

  // column positions of one golden row
  localparam int colCount = 14;
  localparam int colTest = 0;
  localparam int colCommand = 1;
  localparam int colCond = 2;
  localparam int colCndRead = 3;
  localparam int colS1Read = 4;
  localparam int colS0Read = 5;
  localparam int colState = 6;
  localparam int colDn = 7;
  localparam int colIp = 8;
  localparam int colD = 9;
  localparam int colDPtr = 10;
  localparam int colCnd = 11;
  localparam int colS1 = 12;
  localparam int colS0 = 13;

  logic next_state = 1'b0;
  logic rst;
  logic [cmdWidth-1:0] command;
  logic [dataWidth-1:0] cond;
  logic isCndRead;
  logic isS1Read;
  logic isS0Read;
  logic [stateWidth-1:0] state;
  logic nextStateDn;
  logic isIpSaveAllowed;
  logic isDSaveAllowed;
  logic isDSavePtrAllowed;
  logic isCndSaveAllowed;
  logic isS1SaveAllowed;
  logic isS0SaveAllowed;

  logic [31:0] golden [0:colCount*maxRows-1];
  int rowCount = 0;
  int timeLimit = 0;
  int testChecksBase = 0;
  int testErrorsBase = 0;

  `include "tbChecks.svh"

  stateManager UUT (.*);

  always #(clkPeriodNs / 2) next_state = ~next_state;

  function automatic logic [31:0] fieldOf(input int row, input int col);
    return golden[row * colCount + col];
  endfunction

  task automatic applyRow(input int row);
    command <= fieldOf(row, colCommand);
    cond <= fieldOf(row, colCond);
    isCndRead <= (fieldOf(row, colCndRead) != 0);
    isS1Read <= (fieldOf(row, colS1Read) != 0);
    isS0Read <= (fieldOf(row, colS0Read) != 0);
  endtask

  // permissions are combinational and valid before the strobe
  task automatic checkPermits(input int row);
    checkFlag("isIpSaveAllowed", fieldOf(row, colIp) != 0, isIpSaveAllowed);
    checkFlag("isDSaveAllowed", fieldOf(row, colD) != 0, isDSaveAllowed);
    checkFlag("isDSavePtrAllowed", fieldOf(row, colDPtr) != 0, isDSavePtrAllowed);
    checkFlag("isCndSaveAllowed", fieldOf(row, colCnd) != 0, isCndSaveAllowed);
    checkFlag("isS1SaveAllowed", fieldOf(row, colS1) != 0, isS1SaveAllowed);
    checkFlag("isS0SaveAllowed", fieldOf(row, colS0) != 0, isS0SaveAllowed);
  endtask

  task automatic checkAdvance(input int row, input logic dnPrevious);
    logic [31:0] expState;
    expState = fieldOf(row, colState);
    checkState("state", expState[stateWidth-1:0], state);
    checkToggle("nextStateDn", dnPrevious, fieldOf(row, colDn) != 0, nextStateDn);
  endtask

  task automatic finishTest(input int testId);
    $display("test %0d finished: %0d checks, %0d errors", testId,
             checkCount - testChecksBase, errorCount - testErrorsBase);
    testChecksBase = checkCount;
    testErrorsBase = errorCount;
  endtask

  initial begin : stimulus
    logic dnBefore;
    rst = 1'b1;
    command = '0;
    cond = '0;
    isCndRead = 1'b0;
    isS1Read = 1'b0;
    isS0Read = 1'b0;
    $readmemh("verif/stateManagerGolden.mem", golden);
    // rows run up to the end marker with test number zero
    while (rowCount < maxRows && golden[rowCount * colCount] != 0) begin
      rowCount++;
    end
    timeLimit = rowCount * clkPeriodNs * 2 + resetCycles * clkPeriodNs;

    repeat (resetCycles) @(posedge next_state);
    rst <= 1'b0;
    if (rowCount > 0) begin
      applyRow(0);
    end
    @(negedge next_state);
    checkState("state", stWaitForStart, state);
    checkFlag("nextStateDn", 1'b0, nextStateDn);
    finishTest(0);
    if (rowCount == 0) begin
      $display("golden file gave no vectors, nothing was run");
      errorCount++;
    end

    for (int row = 0; row < rowCount; row++) begin
      checkPermits(row);
      dnBefore = nextStateDn;
      @(posedge next_state);
      if (row + 1 < rowCount) begin
        applyRow(row + 1);
      end
      // state settles well before the falling edge
      @(negedge next_state);
      checkAdvance(row, dnBefore);
      if (row + 1 == rowCount || fieldOf(row + 1, colTest) != fieldOf(row, colTest)) begin
        finishTest(fieldOf(row, colTest));
      end
    end

    $display("totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (timeLimit > 0);
    #(timeLimit);
    $display("timeout: the golden vectors did not finish within %0d ns", timeLimit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verif/stateManagerGolden.mem
// test command cond cndRead s1Read s0Read state nextStateDn ip d dPtr cnd s1 s0
// state and nextStateDn are after the strobe, the six permissions before it
1 0FF00000 00000000 0 0 0 01 1 1 0 0 0 0 0
1 00F01200 00000000 0 0 0 02 0 1 0 0 0 0 0
1 00F01200 00000100 0 0 0 03 1 1 1 0 0 0 0
1 0FF40000 00000000 0 0 0 04 0 1 0 1 0 0 0
1 0EF00F00 00000000 0 0 0 05 1 0 1 0 0 0 0
1 05506666 00000001 0 0 0 06 0 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 07 1 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 08 0 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 0c 1 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 0f 0 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 13 1 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 14 0 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 15 1 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 16 0 1 1 0 0 0 0
2 010035F3 00000001 1 1 0 1b 1 1 1 0 0 0 0
3 07506666 00000000 0 0 0 1c 0 1 0 0 0 0 1
3 0F2000FF 00000000 0 0 0 04 1 0 0 0 0 1 0
3 08F0F900 80000000 0 0 0 05 0 0 1 0 1 0 0
3 01501444 00000000 0 0 0 06 1 1 0 0 0 0 1
4 03CD2F64 00000000 0 0 0 07 0 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 08 1 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 0a 0 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 0b 1 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 0d 0 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 12 1 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 13 0 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 14 1 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 15 0 1 0 0 0 0 0
4 03CD2F64 00000000 0 0 0 1b 1 1 0 0 0 0 0
5 037400F0 00000003 0 0 0 1c 0 0 0 1 0 0 1
5 01501444 00000002 0 0 0 04 1 1 1 0 0 0 0
5 0FF40000 00000000 0 0 0 05 0 1 0 1 0 0 0
5 0EF00F00 00000000 0 0 0 06 1 0 1 0 0 0 0
6 05541432 00000005 0 0 0 07 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 08 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 0b 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 0e 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 11 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 13 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 14 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 15 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 17 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 16 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 18 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 19 1 1 1 0 1 1 1
6 05541432 00000005 0 0 0 1a 0 1 1 0 1 1 1
6 05541432 00000005 0 0 0 1b 1 1 1 0 1 1 1
7 05506666 00000001 0 0 0 1c 0 1 1 0 0 0 0
7 0F2000FF 00000000 0 0 0 04 1 0 0 0 0 1 0
// end marker
0 00000000 00000000 0 0 0 00 0 0 0 0 0 0 0

//--- compile.f
+incdir+include
source/cmdPkg.sv
source/seqPkg.sv
source/operandFetchPlanner.sv
source/writebackPermit.sv
source/instructionSequencer.sv
source/stateManager.sv
verif/stateManagerTb.sv

//--- Makefile
# Verilator build and run for the state manager testbench

VERILATOR ?= verilator
TOP ?= stateManagerTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status comes from the search for the pass message
run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
